// File: src/dram_pkg.sv
`default_nettype none

package dram_pkg;

    localparam int BOX_ADDR_W = 8;
    localparam int ING_W      = 12;

    // box number doubles as the memory address
    typedef logic [BOX_ADDR_W-1:0] box_addr_t;
    typedef logic [ING_W-1:0]      ing_amt_t;
    typedef logic [3:0]            month_t;
    typedef logic [4:0]            day_t;

    // saturation limit of one ingredient
    localparam ing_amt_t ING_MAX = 12'd4095;

    // one 64-bit memory word per box
    typedef struct packed {
        ing_amt_t   black_tea;
        ing_amt_t   green_tea;
        ing_amt_t   milk;
        ing_amt_t   pineapple_juice;
        logic [3:0] month_pad;
        month_t     month;
        logic [2:0] day_pad;
        day_t       day;
    } box_t;

    typedef struct packed {
        box_addr_t addr;
        logic      write;
        box_t      data;
    } mem_req_t;

endpackage

`default_nettype wire

// File: src/bev_pkg.sv
`default_nettype none

package bev_pkg;

    typedef enum logic [1:0] {
        MAKE_DRINK = 2'd0,
        SUPPLY     = 2'd1,
        CHECK_DATE = 2'd2
    } action_t;

    typedef enum logic [2:0] {
        BLACK_TEA                = 3'd0,
        MILK_TEA                 = 3'd1,
        EXTRA_MILK_TEA           = 3'd2,
        GREEN_TEA                = 3'd3,
        GREEN_MILK_TEA           = 3'd4,
        PINEAPPLE_JUICE          = 3'd5,
        SUPER_PINEAPPLE_TEA      = 3'd6,
        SUPER_PINEAPPLE_MILK_TEA = 3'd7
    } bev_type_t;

    typedef enum logic [1:0] {
        L = 2'b00,
        M = 2'b01,
        S = 2'b11
    } bev_size_t;

    typedef enum logic [1:0] {
        NO_ERR = 2'd0,
        NO_EXP = 2'd1,
        NO_ING = 2'd2,
        ING_OF = 2'd3
    } err_t;

    typedef struct packed {
        dram_pkg::month_t month;
        dram_pkg::day_t   day;
    } date_t;

    // drink volumes in units
    localparam logic [9:0] SIZE_S = 10'd480;
    localparam logic [9:0] SIZE_M = 10'd720;
    localparam logic [9:0] SIZE_L = 10'd960;

    // quarters of the volume per ingredient: black, green, milk, pineapple
    localparam logic [2:0] RECIPE_PARTS [0:7][0:3] = '{
        '{3'd4, 3'd0, 3'd0, 3'd0},
        '{3'd3, 3'd0, 3'd1, 3'd0},
        '{3'd2, 3'd0, 3'd2, 3'd0},
        '{3'd0, 3'd4, 3'd0, 3'd0},
        '{3'd0, 3'd2, 3'd2, 3'd0},
        '{3'd0, 3'd0, 3'd0, 3'd4},
        '{3'd2, 3'd0, 3'd0, 3'd2},
        '{3'd2, 3'd0, 3'd1, 3'd1}
    };

    // the shared input word, read according to the strobe that is high
    typedef union packed {
        struct packed {logic [9:0] pad; action_t act;}            d_act;
        struct packed {logic [8:0] pad; bev_type_t bev_type;}     d_type;
        struct packed {logic [9:0] pad; bev_size_t size;}         d_size;
        struct packed {logic [2:0] pad; date_t date;}             d_date;
        struct packed {logic [3:0] pad; dram_pkg::box_addr_t box_no;} d_box;
        dram_pkg::ing_amt_t                                       d_ing;
    } in_bus_t;

    typedef struct packed {
        action_t                        act;
        bev_type_t                      bev_type;
        bev_size_t                      size;
        date_t                          today;
        dram_pkg::box_addr_t            box_no;
        dram_pkg::ing_amt_t [0:3]       sup;
    } order_t;

    typedef struct packed {
        order_t         order;
        dram_pkg::box_t box;
    } fetch_t;

    typedef struct packed {
        err_t err;
        logic complete;
    } result_t;

endpackage

`default_nettype wire

// File: src/order_collect.sv
`timescale 1ns/1ns
`default_nettype none

module order_collect (
    input  logic             clk,
    input  logic             inf,
    input  logic             sel_action_valid,
    input  logic             type_valid,
    input  logic             size_valid,
    input  logic             date_valid,
    input  logic             box_no_valid,
    input  logic             box_sup_valid,
    input  bev_pkg::in_bus_t in_data,
    output logic             order_valid,
    output bev_pkg::order_t  order
);
    import bev_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_TYPE,
        ST_SIZE,
        ST_DATE,
        ST_BOX,
        ST_SUP
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic [1:0] sup_cnt;
    logic       last_sup;

    // fourth refill amount closes a supply order
    assign last_sup = box_sup_valid && (sup_cnt == 2'd3);

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
            begin
                if (sel_action_valid)
                begin
                    case (in_data.d_act.act)
                        MAKE_DRINK: state_nxt = ST_TYPE;
                        SUPPLY:     state_nxt = ST_DATE;
                        CHECK_DATE: state_nxt = ST_DATE;
                        default:    state_nxt = ST_IDLE;
                    endcase
                end
            end
            ST_TYPE: state_nxt = type_valid ? ST_SIZE : ST_TYPE;
            ST_SIZE: state_nxt = size_valid ? ST_DATE : ST_SIZE;
            ST_DATE: state_nxt = date_valid ? ST_BOX : ST_DATE;
            ST_BOX:
            begin
                if (box_no_valid)
                begin
                    state_nxt = (order.act == SUPPLY) ? ST_SUP : ST_IDLE;
                end
            end
            ST_SUP:  state_nxt = last_sup ? ST_IDLE : ST_SUP;
            default: state_nxt = ST_IDLE;
        endcase
    end

    // wraps back to zero after the pineapple amount
    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            sup_cnt     <= 2'd0;
            order_valid <= 1'b0;
        end
        else
        begin
            if (state == ST_SUP && box_sup_valid)
            begin
                sup_cnt <= sup_cnt + 2'd1;
            end
            order_valid <= (state == ST_BOX && box_no_valid && order.act != SUPPLY) ||
                           (state == ST_SUP && last_sup);
        end
    end

    // field capture
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && sel_action_valid)
        begin
            order.act <= in_data.d_act.act;
        end
        if (state == ST_TYPE && type_valid)
        begin
            order.bev_type <= in_data.d_type.bev_type;
        end
        if (state == ST_SIZE && size_valid)
        begin
            order.size <= in_data.d_size.size;
        end
        if (state == ST_DATE && date_valid)
        begin
            order.today <= in_data.d_date.date;
        end
        if (state == ST_BOX && box_no_valid)
        begin
            order.box_no <= in_data.d_box.box_no;
        end
        if (state == ST_SUP && box_sup_valid)
        begin
            order.sup[sup_cnt] <= in_data.d_ing;
        end
    end

endmodule

`default_nettype wire

// File: src/dram_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module dram_bridge (
    input  logic               clk,
    input  logic               inf,
    input  logic               order_valid,
    input  bev_pkg::order_t    order,
    output logic               fetch_valid,
    output bev_pkg::fetch_t    fetch,
    input  logic               wb_valid,
    input  dram_pkg::box_t     wb_box,
    output logic               mem_req_valid,
    output dram_pkg::mem_req_t mem_req,
    input  logic               mem_rsp_valid,
    input  dram_pkg::box_t     mem_rsp_data
);
    import bev_pkg::*;
    import dram_pkg::*;

    order_t    cur_order;
    logic      pend_valid;
    box_addr_t wr_addr;
    logic      busy;
    logic      busy_read;
    logic      port_free;
    logic      rd_go;
    box_addr_t rd_addr;

    // the port frees up in the cycle its response arrives
    assign port_free = !busy || mem_rsp_valid;

    // write-back has priority, a read waits for an outstanding write
    assign rd_go   = (order_valid || pend_valid) && port_free && !wb_valid;
    assign rd_addr = order_valid ? order.box_no : cur_order.box_no;

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            pend_valid    <= 1'b0;
            busy          <= 1'b0;
            busy_read     <= 1'b0;
            mem_req_valid <= 1'b0;
            fetch_valid   <= 1'b0;
        end
        else
        begin
            mem_req_valid <= wb_valid || rd_go;
            fetch_valid   <= mem_rsp_valid && busy && busy_read;

            if (rd_go)
            begin
                pend_valid <= 1'b0;
            end
            else if (order_valid)
            begin
                pend_valid <= 1'b1;
            end

            if (wb_valid || rd_go)
            begin
                busy      <= 1'b1;
                busy_read <= rd_go;
            end
            else if (mem_rsp_valid)
            begin
                busy <= 1'b0;
            end
        end
    end

    // request and fetch payload
    always_ff @(posedge clk)
    begin
        if (order_valid)
        begin
            cur_order <= order;
        end

        if (rd_go)
        begin
            wr_addr       <= rd_addr;
            mem_req.addr  <= rd_addr;
            mem_req.write <= 1'b0;
            mem_req.data  <= '0;
        end
        else if (wb_valid)
        begin
            // updated box goes back where it was read from
            mem_req.addr  <= wr_addr;
            mem_req.write <= 1'b1;
            mem_req.data  <= wb_box;
        end

        if (mem_rsp_valid && busy_read)
        begin
            fetch.order <= cur_order;
            fetch.box   <= mem_rsp_data;
        end
    end

endmodule

`default_nettype wire

// File: src/inventory_calc.sv
`timescale 1ns/1ns
`default_nettype none

module inventory_calc (
    input  logic             clk,
    input  logic             inf,
    input  logic             fetch_valid,
    input  bev_pkg::fetch_t  fetch,
    output logic             out_valid,
    output bev_pkg::result_t result,
    output logic             wb_valid,
    output dram_pkg::box_t   wb_box
);
    import bev_pkg::*;
    import dram_pkg::*;

    ing_amt_t [0:3]     box_ing;
    ing_amt_t [0:3]     new_ing;
    logic [9:0]         vol;
    logic [9:0]         quarter;
    logic [9:0]         used [0:3];
    logic signed [13:0] remain [0:3];
    logic [12:0]        sum [0:3];
    logic               expired;
    logic               short_any;
    logic               over_any;
    err_t               err;
    logic               write_back;
    box_t               new_box;

    assign box_ing = {fetch.box.black_tea, fetch.box.green_tea,
                      fetch.box.milk, fetch.box.pineapple_juice};

    // still good if its month is later, or same month and day not passed
    assign expired = !((fetch.box.month > fetch.order.today.month) ||
                       (fetch.box.month == fetch.order.today.month &&
                        fetch.box.day >= fetch.order.today.day));

    always_comb
    begin
        case (fetch.order.size)
            S:       vol = SIZE_S;
            M:       vol = SIZE_M;
            L:       vol = SIZE_L;
            default: vol = 10'd0;
        endcase
    end

    assign quarter = vol >> 2;

    always_comb
    begin
        short_any = 1'b0;
        over_any  = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            used[i]   = quarter * {7'd0, RECIPE_PARTS[fetch.order.bev_type][i]};
            remain[i] = $signed({2'b00, box_ing[i]}) - $signed({4'b0000, used[i]});
            sum[i]    = {1'b0, box_ing[i]} + {1'b0, fetch.order.sup[i]};
            short_any = short_any | remain[i][13];
            over_any  = over_any | (sum[i] > {1'b0, ING_MAX});
            if (fetch.order.act == SUPPLY)
            begin
                new_ing[i] = (sum[i] > {1'b0, ING_MAX}) ? ING_MAX : sum[i][11:0];
            end
            else
            begin
                new_ing[i] = remain[i][11:0];
            end
        end
    end

    // drinks keep the stored date, refills restamp it
    always_comb
    begin
        new_box                 = fetch.box;
        new_box.black_tea       = new_ing[0];
        new_box.green_tea       = new_ing[1];
        new_box.milk            = new_ing[2];
        new_box.pineapple_juice = new_ing[3];
        if (fetch.order.act == SUPPLY)
        begin
            new_box.month_pad = '0;
            new_box.month     = fetch.order.today.month;
            new_box.day_pad   = '0;
            new_box.day       = fetch.order.today.day;
        end
    end

    always_comb
    begin
        err        = NO_ERR;
        write_back = 1'b0;
        case (fetch.order.act)
            MAKE_DRINK:
            begin
                if (expired)
                begin
                    err = NO_EXP;
                end
                else if (short_any)
                begin
                    err = NO_ING;
                end
                else
                begin
                    write_back = 1'b1;
                end
            end
            SUPPLY:
            begin
                err        = over_any ? ING_OF : NO_ERR;
                write_back = 1'b1;
            end
            CHECK_DATE: err = expired ? NO_EXP : NO_ERR;
            default:    err = NO_ERR;
        endcase
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            out_valid <= 1'b0;
            wb_valid  <= 1'b0;
            result    <= '{err: NO_ERR, complete: 1'b0};
        end
        else
        begin
            out_valid <= fetch_valid;
            wb_valid  <= fetch_valid && write_back;
            if (fetch_valid)
            begin
                result <= '{err: err, complete: (err == NO_ERR)};
            end
            else
            begin
                result <= '{err: NO_ERR, complete: 1'b0};
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_valid)
        begin
            wb_box <= new_box;
        end
    end

endmodule

`default_nettype wire

// File: src/bev_top.sv
`timescale 1ns/1ns
`default_nettype none

module bev_top (
    input  logic               clk,
    input  logic               inf,
    input  logic               sel_action_valid,
    input  logic               type_valid,
    input  logic               size_valid,
    input  logic               date_valid,
    input  logic               box_no_valid,
    input  logic               box_sup_valid,
    input  bev_pkg::in_bus_t   in_data,
    output logic               out_valid,
    output bev_pkg::result_t   result,
    output logic               mem_req_valid,
    output dram_pkg::mem_req_t mem_req,
    input  logic               mem_rsp_valid,
    input  dram_pkg::box_t     mem_rsp_data
);
    import bev_pkg::*;
    import dram_pkg::*;

    logic   order_valid;
    order_t order;
    logic   fetch_valid;
    fetch_t fetch;
    logic   wb_valid;
    box_t   wb_box;

    order_collect u_collect (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .box_sup_valid    (box_sup_valid),
        .in_data          (in_data),
        .order_valid      (order_valid),
        .order            (order)
    );

    dram_bridge u_bridge (
        .clk           (clk),
        .inf           (inf),
        .order_valid   (order_valid),
        .order         (order),
        .fetch_valid   (fetch_valid),
        .fetch         (fetch),
        .wb_valid      (wb_valid),
        .wb_box        (wb_box),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    inventory_calc u_calc (
        .clk         (clk),
        .inf         (inf),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .out_valid   (out_valid),
        .result      (result),
        .wb_valid    (wb_valid),
        .wb_box      (wb_box)
    );

endmodule

`default_nettype wire

// File: test/bev_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module bev_asserts (
    input logic             clk,
    input logic             inf,
    input logic             out_valid,
    input bev_pkg::result_t result,
    input logic             mem_req_valid,
    input logic             mem_rsp_valid
);
    import bev_pkg::*;

    logic req_open;

    // open from the request until its response
    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            req_open <= 1'b0;
        end
        else if (mem_rsp_valid)
        begin
            req_open <= 1'b0;
        end
        else if (mem_req_valid)
        begin
            req_open <= 1'b1;
        end
    end

    out_valid_pulse: assert property (
        @(posedge clk) disable iff (!inf) out_valid |=> !out_valid)
        else $error("out_valid held longer than one cycle");

    complete_means_ok: assert property (
        @(posedge clk) disable iff (!inf)
        result.complete |-> (out_valid && result.err == NO_ERR))
        else $error("complete set without out_valid or together with an error code");

    one_request_in_flight: assert property (
        @(posedge clk) disable iff (!inf) mem_req_valid |-> !req_open)
        else $error("memory request issued while another is outstanding");

    // outputs stay quiet during reset
    quiet_in_reset: assert property (
        @(posedge clk) !inf |-> (!out_valid && !mem_req_valid && !result.complete))
        else $error("output active while reset is low");

endmodule

bind bev_top bev_asserts u_asserts (
    .clk           (clk),
    .inf           (inf),
    .out_valid     (out_valid),
    .result        (result),
    .mem_req_valid (mem_req_valid),
    .mem_rsp_valid (mem_rsp_valid)
);

`default_nettype wire

// File: test/bev_tb.sv
`timescale 1ns/1ns
`default_nettype none

module bev_tb;
    import bev_pkg::*;
    import dram_pkg::*;

    localparam int          N_ACTIONS  = 400;
    localparam int          CLK_PERIOD = 20;
    localparam int          BOX_RANGE  = 6;
    localparam logic [31:0] SEED       = 32'h843ec479;

    // field codes for drive_strobe
    localparam int FLD_ACT  = 0;
    localparam int FLD_TYPE = 1;
    localparam int FLD_SIZE = 2;
    localparam int FLD_DATE = 3;
    localparam int FLD_BOX  = 4;
    localparam int FLD_SUP  = 5;

    logic     clk;
    logic     inf;
    logic     sel_action_valid;
    logic     type_valid;
    logic     size_valid;
    logic     date_valid;
    logic     box_no_valid;
    logic     box_sup_valid;
    in_bus_t  in_data;
    logic     out_valid;
    result_t  result;
    logic     mem_req_valid;
    mem_req_t mem_req;
    logic     mem_rsp_valid;
    box_t     mem_rsp_data;

    // memory model
    box_t mem [0:255];
    logic req_busy;
    int   rsp_wait;

    // reference model and expected write-backs in order
    box_t      ref_mem [0:255];
    box_addr_t exp_wr_addr [$];
    box_t      exp_wr_box [$];
    box_addr_t exp_rd_addr;
    int        error_count;

    bev_top dut (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .box_sup_valid    (box_sup_valid),
        .in_data          (in_data),
        .out_valid        (out_valid),
        .result           (result),
        .mem_req_valid    (mem_req_valid),
        .mem_req          (mem_req),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp_data     (mem_rsp_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_result(input string name, input result_t got, input result_t exp);
        if (got !== exp)
        begin
            report_error($sformatf("CHECK FAILED time=%0t %s got=%h expected=%h",
                                   $time, name, got, exp));
        end
    endtask

    task automatic check_box(input string name, input box_t got, input box_t exp);
        if (got !== exp)
        begin
            report_error($sformatf("CHECK FAILED time=%0t %s got=%h expected=%h",
                                   $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input box_addr_t got, input box_addr_t exp);
        if (got !== exp)
        begin
            report_error($sformatf("CHECK FAILED time=%0t %s got=%h expected=%h",
                                   $time, name, got, exp));
        end
    endtask

    function automatic box_t random_box();
        box_t b;
        b                 = '0;
        b.black_tea       = ing_amt_t'($urandom_range(4095, 0));
        b.green_tea       = ing_amt_t'($urandom_range(4095, 0));
        b.milk            = ing_amt_t'($urandom_range(4095, 0));
        b.pineapple_juice = ing_amt_t'($urandom_range(4095, 0));
        b.month           = month_t'($urandom_range(12, 1));
        b.day             = day_t'($urandom_range(28, 1));
        return b;
    endfunction

    function automatic in_bus_t noise_word();
        return in_bus_t'(12'($urandom_range(4095, 0)));
    endfunction

    // quarters per ingredient: black, green, milk, pineapple
    function automatic int recipe_part(input bev_type_t bt, input int ing);
        int p [0:3];
        case (bt)
            BLACK_TEA:                p = '{4, 0, 0, 0};
            MILK_TEA:                 p = '{3, 0, 1, 0};
            EXTRA_MILK_TEA:           p = '{2, 0, 2, 0};
            GREEN_TEA:                p = '{0, 4, 0, 0};
            GREEN_MILK_TEA:           p = '{0, 2, 2, 0};
            PINEAPPLE_JUICE:          p = '{0, 0, 0, 4};
            SUPER_PINEAPPLE_TEA:      p = '{2, 0, 0, 2};
            SUPER_PINEAPPLE_MILK_TEA: p = '{2, 0, 1, 1};
            default:                  p = '{0, 0, 0, 0};
        endcase
        return p[ing];
    endfunction

    function automatic void predict(input action_t act, input bev_type_t bt,
                                    input bev_size_t sz, input date_t today,
                                    input ing_amt_t [0:3] sup, input box_t b,
                                    output result_t r, output logic wr, output box_t nb);
        int   cur [0:3];
        int   nv [0:3];
        int   vol;
        logic expired;
        logic short_any;
        logic over_any;
        cur[0] = int'(b.black_tea);
        cur[1] = int'(b.green_tea);
        cur[2] = int'(b.milk);
        cur[3] = int'(b.pineapple_juice);
        case (sz)
            S:       vol = 480;
            M:       vol = 720;
            default: vol = 960;
        endcase
        // month and day folded onto one day scale
        expired = (int'(b.month) * 32 + int'(b.day)) <
                  (int'(today.month) * 32 + int'(today.day));
        short_any = 1'b0;
        over_any  = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            if (act == SUPPLY)
            begin
                nv[i] = cur[i] + int'(sup[i]);
                if (nv[i] > 4095)
                begin
                    over_any = 1'b1;
                    nv[i]    = 4095;
                end
            end
            else
            begin
                nv[i] = cur[i] - (vol / 4) * recipe_part(bt, i);
                if (nv[i] < 0)
                begin
                    short_any = 1'b1;
                end
            end
        end
        nb                 = b;
        nb.black_tea       = ing_amt_t'(nv[0]);
        nb.green_tea       = ing_amt_t'(nv[1]);
        nb.milk            = ing_amt_t'(nv[2]);
        nb.pineapple_juice = ing_amt_t'(nv[3]);
        if (act == SUPPLY)
        begin
            nb.month_pad = '0;
            nb.month     = today.month;
            nb.day_pad   = '0;
            nb.day       = today.day;
        end
        wr    = 1'b0;
        r.err = NO_ERR;
        case (act)
            MAKE_DRINK:
            begin
                if (expired)
                begin
                    r.err = NO_EXP;
                end
                else if (short_any)
                begin
                    r.err = NO_ING;
                end
                else
                begin
                    wr = 1'b1;
                end
            end
            SUPPLY:
            begin
                r.err = over_any ? ING_OF : NO_ERR;
                wr    = 1'b1;
            end
            default: r.err = expired ? NO_EXP : NO_ERR;
        endcase
        r.complete = (r.err == NO_ERR);
    endfunction

    task automatic clear_strobes();
        sel_action_valid = 1'b0;
        type_valid       = 1'b0;
        size_valid       = 1'b0;
        date_valid       = 1'b0;
        box_no_valid     = 1'b0;
        box_sup_valid    = 1'b0;
    endtask

    // nothing may come out while an order is still being entered
    task automatic check_quiet(input logic first);
        if (out_valid)
        begin
            report_error($sformatf("out_valid went high at %0t before the order was complete",
                                   $time));
        end
        if (first && mem_req_valid)
        begin
            report_error($sformatf("memory request at %0t before the first order was complete",
                                   $time));
        end
    endtask

    task automatic drive_strobe(input int field, input in_bus_t word, input logic first);
        int idle;
        idle = $urandom_range(3, 0);
        repeat (idle)
        begin
            @(negedge clk);
            clear_strobes();
            check_quiet(first);
        end
        @(negedge clk);
        clear_strobes();
        check_quiet(first);
        in_data = word;
        case (field)
            FLD_ACT:  sel_action_valid = 1'b1;
            FLD_TYPE: type_valid       = 1'b1;
            FLD_SIZE: size_valid       = 1'b1;
            FLD_DATE: date_valid       = 1'b1;
            FLD_BOX:  box_no_valid     = 1'b1;
            default:  box_sup_valid    = 1'b1;
        endcase
    endtask

    task automatic wait_out_valid();
        @(negedge clk);
        clear_strobes();
        while (!out_valid)
        begin
            @(negedge clk);
        end
    endtask

    task automatic run_action(input logic first);
        action_t        act;
        bev_type_t      bt;
        bev_size_t      sz;
        date_t          today;
        box_addr_t      box_no;
        ing_amt_t [0:3] sup;
        in_bus_t        word;
        result_t        exp_res;
        logic           exp_wr;
        box_t           exp_box;

        case ($urandom_range(2, 0))
            0:       act = MAKE_DRINK;
            1:       act = SUPPLY;
            default: act = CHECK_DATE;
        endcase
        bt = bev_type_t'(3'($urandom_range(7, 0)));
        case ($urandom_range(2, 0))
            0:       sz = S;
            1:       sz = M;
            default: sz = L;
        endcase
        today.month = month_t'($urandom_range(12, 1));
        today.day   = day_t'($urandom_range(28, 1));
        box_no      = box_addr_t'($urandom_range(BOX_RANGE - 1, 0));
        // mostly small refills, now and then a large one to force overflow
        for (int i = 0; i < 4; i++)
        begin
            if ($urandom_range(3, 0) == 0)
            begin
                sup[i] = ing_amt_t'($urandom_range(4095, 0));
            end
            else
            begin
                sup[i] = ing_amt_t'($urandom_range(700, 0));
            end
        end

        predict(act, bt, sz, today, sup, ref_mem[box_no], exp_res, exp_wr, exp_box);
        if (exp_wr)
        begin
            ref_mem[box_no] = exp_box;
            exp_wr_addr.push_back(box_no);
            exp_wr_box.push_back(exp_box);
        end
        exp_rd_addr = box_no;

        word           = noise_word();
        word.d_act.act = act;
        drive_strobe(FLD_ACT, word, first);
        if (act == MAKE_DRINK)
        begin
            word                = noise_word();
            word.d_type.bev_type = bt;
            drive_strobe(FLD_TYPE, word, first);
            word             = noise_word();
            word.d_size.size = sz;
            drive_strobe(FLD_SIZE, word, first);
        end
        word             = noise_word();
        word.d_date.date = today;
        drive_strobe(FLD_DATE, word, first);
        word              = noise_word();
        word.d_box.box_no = box_no;
        drive_strobe(FLD_BOX, word, first);
        if (act == SUPPLY)
        begin
            for (int i = 0; i < 4; i++)
            begin
                word.d_ing = sup[i];
                drive_strobe(FLD_SUP, word, first);
            end
        end

        wait_out_valid();
        check_result("result", result, exp_res);
    endtask

    // responds 1 to 4 cycles after each request
    always @(negedge clk)
    begin
        if (!inf)
        begin
            mem_rsp_valid = 1'b0;
            req_busy      = 1'b0;
        end
        else
        begin
            if (mem_rsp_valid)
            begin
                mem_rsp_valid = 1'b0;
                req_busy      = 1'b0;
            end
            if (mem_req_valid)
            begin
                if (req_busy)
                begin
                    report_error($sformatf("second memory request at %0t while one is open",
                                           $time));
                end
                req_busy = 1'b1;
                rsp_wait = $urandom_range(4, 1);
                if (mem_req.write)
                begin
                    if (exp_wr_addr.size() == 0)
                    begin
                        report_error($sformatf("unexpected write to box %0d at %0t",
                                               mem_req.addr, $time));
                    end
                    check_addr("mem_req.addr", mem_req.addr, exp_wr_addr.pop_front());
                    check_box("mem_req.data", mem_req.data, exp_wr_box.pop_front());
                    mem[mem_req.addr] = mem_req.data;
                end
                else
                begin
                    check_addr("mem_req.addr", mem_req.addr, exp_rd_addr);
                    mem_rsp_data = mem[mem_req.addr];
                end
            end
            else if (req_busy)
            begin
                rsp_wait--;
                if (rsp_wait == 0)
                begin
                    mem_rsp_valid = 1'b1;
                end
            end
        end
    end

    initial
    begin
        #((N_ACTIONS + 1) * 60 * CLK_PERIOD);
        report_error("watchdog expired before all actions finished");
    end

    initial
    begin
        void'($urandom(SEED));
        error_count   = 0;
        req_busy      = 1'b0;
        rsp_wait      = 0;
        exp_rd_addr   = '0;
        in_data       = '0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        clear_strobes();
        for (int a = 0; a < 256; a++)
        begin
            mem[a]     = random_box();
            ref_mem[a] = mem[a];
        end

        inf = 1'b1;
        #1;
        inf = 1'b0;
        repeat (5)
        begin
            @(negedge clk);
        end
        inf = 1'b1;

        for (int n = 0; n < N_ACTIONS; n++)
        begin
            run_action(n == 0);
        end

        // last write-back must still reach memory
        while (exp_wr_addr.size() != 0 || req_busy)
        begin
            @(negedge clk);
        end
        repeat (8)
        begin
            @(negedge clk);
        end

        if (error_count == 0)
        begin
            $display("NO ERRORS");
            $finish;
        end
        else
        begin
            stop_run();
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
src/dram_pkg.sv
src/bev_pkg.sv
src/order_collect.sv
src/dram_bridge.sv
src/inventory_calc.sv
src/bev_top.sv
test/bev_asserts.sv
test/bev_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = bev_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
